/* source/lstm_pkg.sv */
`default_nettype none

package lstm_pkg;

        ////////////////////////////////////////
        // Fixed-point format
        ////////////////////////////////////////

        // Q3.20 word
        localparam int WIDTH    = 24;
        localparam int FRAC     = 20;

        // Learning rate of 0.125
        localparam int LR_SHIFT = 3;

        ////////////////////////////////////////
        // Layer size
        ////////////////////////////////////////

        localparam int NUM_CELLS   = 8;
        localparam int NUM_INPUTS  = 8;
        localparam int NUM_WEIGHTS = NUM_CELLS * NUM_INPUTS;
        localparam int ADDR_W      = $clog2(NUM_WEIGHTS);

        ////////////////////////////////////////
        // Shared types
        ////////////////////////////////////////

        typedef logic signed [WIDTH-1:0] fixed_t;
        typedef logic [ADDR_W-1:0]       addr_t;

endpackage

`default_nettype wire

/* source/grad_product.sv */
`timescale 1ns/10ps
`default_nettype none

module grad_product (
        input  wire              i_clk,
        input  wire              i_rst_n,
        input  wire              i_grad_valid,
        input  wire lstm_pkg::fixed_t i_dgate,
        input  wire lstm_pkg::fixed_t i_x,
        input  wire lstm_pkg::addr_t  i_grad_addr,
        input  wire              i_acc_cost,
        input  wire              i_clr_cost,
        output logic             o_grad_wr,
        output lstm_pkg::addr_t  o_grad_addr,
        output lstm_pkg::fixed_t o_grad,
        output lstm_pkg::fixed_t o_cost
);
        import lstm_pkg::*;

        logic signed [2*WIDTH-1:0] prod_q;
        logic                      prod_vld_q;
        addr_t                     prod_addr_q;
        fixed_t                    grad_scaled;
        fixed_t                    grad_lr;
        fixed_t                    cost_acc;

        ////////////////////////////////////////
        // Stage one: full-width product
        ////////////////////////////////////////

        always_ff @(posedge i_clk) begin
                if (!i_rst_n) begin
                        prod_vld_q <= 1'b0;
                end else begin
                        prod_vld_q <= i_grad_valid;
                end
        end

        always_ff @(posedge i_clk) begin
                if (i_grad_valid) begin
                        prod_q      <= i_dgate * i_x;
                        prod_addr_q <= i_grad_addr;
                end
        end

        ////////////////////////////////////////
        // Stage two: scale and learning rate
        ////////////////////////////////////////

        // Drop the fraction bits, keep the low word
        assign grad_scaled = fixed_t'(prod_q >>> FRAC);

        // Same effect as multiplying by the rate
        assign grad_lr = grad_scaled >>> LR_SHIFT;

        always_ff @(posedge i_clk) begin
                if (!i_rst_n) begin
                        o_grad_wr <= 1'b0;
                end else begin
                        o_grad_wr <= prod_vld_q;
                end
        end

        always_ff @(posedge i_clk) begin
                if (prod_vld_q) begin
                        o_grad      <= grad_lr;
                        o_grad_addr <= prod_addr_q;
                end
        end

        ////////////////////////////////////////
        // Cost accumulator
        ////////////////////////////////////////

        // Clear wins over accumulate
        always_ff @(posedge i_clk) begin
                if (!i_rst_n || i_clr_cost) begin
                        cost_acc <= '0;
                end else if (i_acc_cost) begin
                        cost_acc <= cost_acc + i_dgate;
                end
        end

        // Half of the summed deltas
        assign o_cost = cost_acc >>> 1;

endmodule

`default_nettype wire

/* source/dual_port_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module dual_port_ram #(
        parameter int DEPTH     = lstm_pkg::NUM_WEIGHTS,
        parameter int ADDR_BITS = lstm_pkg::ADDR_W
) (
        input  wire                   i_clk,
        input  wire                   i_rst_n,
        input  wire                   i_wr_a,
        input  wire [ADDR_BITS-1:0]   i_addr_a,
        input  wire lstm_pkg::fixed_t i_data_a,
        output lstm_pkg::fixed_t      o_data_a,
        input  wire [ADDR_BITS-1:0]   i_addr_b,
        output lstm_pkg::fixed_t      o_data_b
);
        import lstm_pkg::*;

        fixed_t mem [DEPTH];

        // Port A writes and reads the old word, port B only reads
        always_ff @(posedge i_clk) begin
                if (!i_rst_n) begin
                        for (int i = 0; i < DEPTH; i++) begin
                                mem[i] <= '0;
                        end
                        o_data_a <= '0;
                        o_data_b <= '0;
                end else begin
                        if (i_wr_a) begin
                                mem[i_addr_a] <= i_data_a;
                        end
                        o_data_a <= mem[i_addr_a];
                        // Same-edge write to this address not yet visible
                        o_data_b <= mem[i_addr_b];
                end
        end

endmodule

`default_nettype wire

/* source/weight_updater.sv */
`timescale 1ns/10ps
`default_nettype none

module weight_updater (
        input  wire                   i_clk,
        input  wire                   i_rst_n,
        input  wire                   i_upd,
        input  wire lstm_pkg::addr_t  i_upd_addr,
        output lstm_pkg::addr_t       o_grad_rd_addr,
        input  wire lstm_pkg::fixed_t i_grad,
        input  wire                   i_wr_w,
        input  wire lstm_pkg::addr_t  i_w_addr,
        input  wire lstm_pkg::fixed_t i_w_data,
        input  wire lstm_pkg::addr_t  i_rd_w_addr,
        output lstm_pkg::fixed_t      o_w_data
);
        import lstm_pkg::*;

        logic   upd_q;
        addr_t  upd_addr_q;
        addr_t  rd_addr;
        addr_t  wr_addr;
        logic   wr_en;
        fixed_t wr_data;
        fixed_t w_new;

        ////////////////////////////////////////
        // Read side
        ////////////////////////////////////////

        // Update read takes the port over host readback
        assign rd_addr        = i_upd ? i_upd_addr : i_rd_w_addr;
        assign o_grad_rd_addr = i_upd_addr;

        always_ff @(posedge i_clk) begin
                if (!i_rst_n) begin
                        upd_q <= 1'b0;
                end else begin
                        upd_q <= i_upd;
                end
        end

        always_ff @(posedge i_clk) begin
                upd_addr_q <= i_upd_addr;
        end

        ////////////////////////////////////////
        // Write-back
        ////////////////////////////////////////

        // Weight and gradient both arrive one cycle after the strobe
        assign w_new = o_w_data - i_grad;

        // Host load is dropped when a write-back is due
        assign wr_en   = upd_q | i_wr_w;
        assign wr_addr = upd_q ? upd_addr_q : i_w_addr;
        assign wr_data = upd_q ? w_new : i_w_data;

        dual_port_ram #(
                .DEPTH     (NUM_WEIGHTS),
                .ADDR_BITS (ADDR_W)
        ) u_weight_mem (
                .i_clk    (i_clk),
                .i_rst_n  (i_rst_n),
                .i_wr_a   (wr_en),
                .i_addr_a (wr_addr),
                .i_data_a (wr_data),
                .o_data_a (),
                .i_addr_b (rd_addr),
                .o_data_b (o_w_data)
        );

endmodule

`default_nettype wire

/* source/lstm_weight_update.sv */
`timescale 1ns/10ps
`default_nettype none

module lstm_weight_update (
        input  wire                   i_clk,
        input  wire                   i_rst_n,
        input  wire                   i_grad_valid,
        input  wire lstm_pkg::fixed_t i_dgate,
        input  wire lstm_pkg::fixed_t i_x,
        input  wire lstm_pkg::addr_t  i_grad_addr,
        input  wire                   i_acc_cost,
        input  wire                   i_clr_cost,
        input  wire                   i_upd,
        input  wire lstm_pkg::addr_t  i_upd_addr,
        input  wire                   i_wr_w,
        input  wire lstm_pkg::addr_t  i_w_addr,
        input  wire lstm_pkg::fixed_t i_w_data,
        input  wire lstm_pkg::addr_t  i_rd_w_addr,
        output lstm_pkg::fixed_t      o_w_data,
        output lstm_pkg::fixed_t      o_cost
);
        import lstm_pkg::*;

        logic   grad_wr;
        addr_t  grad_wr_addr;
        fixed_t grad_wr_data;
        addr_t  grad_rd_addr;
        fixed_t grad_rd_data;

        ////////////////////////////////////////
        // Gradient producer
        ////////////////////////////////////////

        grad_product u_grad (
                .i_clk        (i_clk),
                .i_rst_n      (i_rst_n),
                .i_grad_valid (i_grad_valid),
                .i_dgate      (i_dgate),
                .i_x          (i_x),
                .i_grad_addr  (i_grad_addr),
                .i_acc_cost   (i_acc_cost),
                .i_clr_cost   (i_clr_cost),
                .o_grad_wr    (grad_wr),
                .o_grad_addr  (grad_wr_addr),
                .o_grad       (grad_wr_data),
                .o_cost       (o_cost)
        );

        // One gradient per weight, always accepts
        dual_port_ram #(
                .DEPTH     (NUM_WEIGHTS),
                .ADDR_BITS (ADDR_W)
        ) u_grad_buf (
                .i_clk    (i_clk),
                .i_rst_n  (i_rst_n),
                .i_wr_a   (grad_wr),
                .i_addr_a (grad_wr_addr),
                .i_data_a (grad_wr_data),
                .o_data_a (),
                .i_addr_b (grad_rd_addr),
                .o_data_b (grad_rd_data)
        );

        ////////////////////////////////////////
        // Weight store and update
        ////////////////////////////////////////

        weight_updater u_upd (
                .i_clk          (i_clk),
                .i_rst_n        (i_rst_n),
                .i_upd          (i_upd),
                .i_upd_addr     (i_upd_addr),
                .o_grad_rd_addr (grad_rd_addr),
                .i_grad         (grad_rd_data),
                .i_wr_w         (i_wr_w),
                .i_w_addr       (i_w_addr),
                .i_w_data       (i_w_data),
                .i_rd_w_addr    (i_rd_w_addr),
                .o_w_data       (o_w_data)
        );

endmodule

`default_nettype wire

/* verification/tb_lstm_weight_update.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_lstm_weight_update;
        import lstm_pkg::*;

        localparam int CLK_PERIOD  = 40;
        localparam int RST_CYCLES  = 10;
        localparam int SINGLE_N    = 6;
        localparam int PIPE_N      = 8;
        localparam int COST_N      = 24;

        // Cycle budget of each test
        localparam int T0_CYC      = RST_CYCLES + 2;
        localparam int T1_CYC      = 2 + 2 * NUM_WEIGHTS;
        localparam int T2_CYC      = 1 + 3 * NUM_WEIGHTS;
        localparam int T3_CYC      = 8 * SINGLE_N;
        localparam int T4_CYC      = 3 * PIPE_N + 2 * NUM_WEIGHTS;
        localparam int T5_CYC      = 2 * COST_N + 3;
        localparam int TEST_CYCLES = T0_CYC + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC;

        logic   clk = 1'b0;
        logic   rst_n;
        logic   grad_valid;
        fixed_t dgate;
        fixed_t x;
        addr_t  grad_addr;
        logic   acc_cost;
        logic   clr_cost;
        logic   upd;
        addr_t  upd_addr;
        logic   wr_w;
        addr_t  w_addr;
        fixed_t w_data;
        addr_t  rd_w_addr;
        fixed_t w_data_out;
        fixed_t cost;

        // Reference model state
        fixed_t      model_w [NUM_WEIGHTS];
        fixed_t      cost_model;
        logic [15:0] lfsr_state = 16'd25829;

        always #(CLK_PERIOD / 2) clk = ~clk;

        lstm_weight_update UUT (
                .i_clk        (clk),
                .i_rst_n      (rst_n),
                .i_grad_valid (grad_valid),
                .i_dgate      (dgate),
                .i_x          (x),
                .i_grad_addr  (grad_addr),
                .i_acc_cost   (acc_cost),
                .i_clr_cost   (clr_cost),
                .i_upd        (upd),
                .i_upd_addr   (upd_addr),
                .i_wr_w       (wr_w),
                .i_w_addr     (w_addr),
                .i_w_data     (w_data),
                .i_rd_w_addr  (rd_w_addr),
                .o_w_data     (w_data_out),
                .o_cost       (cost)
        );

        ////////////////////////////////////////
        // Helpers
        ////////////////////////////////////////

        // x^16 + x^14 + x^13 + x^11, one step per bit
        function automatic logic [31:0] rand_bits(input int n);
                logic [31:0] v;
                logic        fb;
                v = '0;
                for (int i = 0; i < n; i++) begin
                        fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
                        lfsr_state = {lfsr_state[14:0], fb};
                        v          = {v[30:0], fb};
                end
                return v;
        endfunction

        // Product, drop fraction bits, then divide by eight with sign kept
        function automatic fixed_t model_gradient(input fixed_t d, input fixed_t xv);
                logic signed [2*WIDTH-1:0] full;
                fixed_t                    scaled;
                full   = $signed({{WIDTH{d[WIDTH-1]}}, d}) * $signed({{WIDTH{xv[WIDTH-1]}}, xv});
                scaled = full[FRAC +: WIDTH];
                return {{LR_SHIFT{scaled[WIDTH-1]}}, scaled[WIDTH-1:LR_SHIFT]};
        endfunction

        task automatic check_equal(input string name, input fixed_t actual, input fixed_t expected);
                if (actual !== expected) begin
                        $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
                        $display("sim failed");
                        $fatal(1, "Value mismatch");
                end
        endtask

        task automatic read_back_check(input addr_t a);
                @(posedge clk);
                rd_w_addr <= a;
                @(posedge clk);
                @(negedge clk);
                check_equal($sformatf("o_w_data[%0d]", a), w_data_out, model_w[a]);
        endtask

        task automatic check_all_weights();
                for (int i = 0; i < NUM_WEIGHTS; i++) begin
                        read_back_check(addr_t'(i));
                end
        endtask

        ////////////////////////////////////////
        // Tests
        ////////////////////////////////////////

        task automatic check_reset_state();
                for (int i = 0; i < NUM_WEIGHTS; i++) begin
                        model_w[i] = '0;
                end
                cost_model = '0;
                @(negedge clk);
                check_equal("o_cost", cost, '0);
                check_all_weights();
        endtask

        task automatic load_weights();
                fixed_t v;
                for (int i = 0; i < NUM_WEIGHTS; i++) begin
                        v = fixed_t'(rand_bits(WIDTH));
                        @(posedge clk);
                        wr_w       <= 1'b1;
                        w_addr     <= addr_t'(i);
                        w_data     <= v;
                        model_w[i] = v;
                end
                @(posedge clk);
                wr_w <= 1'b0;
                check_all_weights();
        endtask

        task automatic single_updates();
                fixed_t d;
                fixed_t xv;
                addr_t  a;
                for (int i = 0; i < SINGLE_N; i++) begin
                        d  = fixed_t'(rand_bits(WIDTH));
                        xv = fixed_t'(rand_bits(WIDTH));
                        a  = addr_t'(rand_bits(ADDR_W));
                        // Make sure both signs of each operand show up
                        if (i == 0) d[WIDTH-1] = 1'b1;
                        if (i == 1) xv[WIDTH-1] = 1'b1;
                        if (i == 2) d[WIDTH-1] = 1'b0;
                        @(posedge clk);
                        grad_valid <= 1'b1;
                        dgate      <= d;
                        x          <= xv;
                        grad_addr  <= a;
                        @(posedge clk);
                        grad_valid <= 1'b0;
                        repeat (2) @(posedge clk);
                        upd      <= 1'b1;
                        upd_addr <= a;
                        @(posedge clk);
                        upd        <= 1'b0;
                        model_w[a] = model_w[a] - model_gradient(d, xv);
                        read_back_check(a);
                end
        endtask

        task automatic pipelined_traffic();
                fixed_t d;
                fixed_t xv;
                addr_t  base;
                fixed_t grads [PIPE_N];
                base = addr_t'(rand_bits(ADDR_W));
                for (int i = 0; i < PIPE_N; i++) begin
                        d        = fixed_t'(rand_bits(WIDTH));
                        xv       = fixed_t'(rand_bits(WIDTH));
                        grads[i] = model_gradient(d, xv);
                        @(posedge clk);
                        grad_valid <= 1'b1;
                        dgate      <= d;
                        x          <= xv;
                        grad_addr  <= base + addr_t'(i);
                end
                @(posedge clk);
                grad_valid <= 1'b0;
                repeat (2) @(posedge clk);
                // Back-to-back updates, all to different weights
                for (int i = 0; i < PIPE_N; i++) begin
                        @(posedge clk);
                        upd      <= 1'b1;
                        upd_addr <= base + addr_t'(i);
                        model_w[base + addr_t'(i)] = model_w[base + addr_t'(i)] - grads[i];
                end
                @(posedge clk);
                upd <= 1'b0;
                check_all_weights();
        endtask

        task automatic cost_accumulation();
                fixed_t d;
                for (int i = 0; i < COST_N; i++) begin
                        d = fixed_t'(rand_bits(WIDTH));
                        @(posedge clk);
                        acc_cost   <= 1'b1;
                        dgate      <= d;
                        cost_model = cost_model + d;
                        @(posedge clk);
                        acc_cost <= 1'b0;
                        @(negedge clk);
                        check_equal("o_cost", cost, {cost_model[WIDTH-1], cost_model[WIDTH-1:1]});
                end
                @(posedge clk);
                clr_cost <= 1'b1;
                @(posedge clk);
                clr_cost   <= 1'b0;
                cost_model = '0;
                @(negedge clk);
                check_equal("o_cost", cost, '0);
        endtask

        ////////////////////////////////////////
        // Main sequence and watchdog
        ////////////////////////////////////////

        initial begin
                rst_n      <= 1'b0;
                grad_valid <= 1'b0;
                dgate      <= '0;
                x          <= '0;
                grad_addr  <= '0;
                acc_cost   <= 1'b0;
                clr_cost   <= 1'b0;
                upd        <= 1'b0;
                upd_addr   <= '0;
                wr_w       <= 1'b0;
                w_addr     <= '0;
                w_data     <= '0;
                rd_w_addr  <= '0;
                repeat (RST_CYCLES) @(posedge clk);
                rst_n <= 1'b1;
                @(posedge clk);
                check_reset_state();
                load_weights();
                single_updates();
                pipelined_traffic();
                cost_accumulation();
                $display("sim passed");
                $finish;
        end

        initial begin
                #(2 * TEST_CYCLES * CLK_PERIOD);
                $display("Timeout: the tests did not complete within the time limit");
                $display("sim failed");
                $fatal(1, "Watchdog expired");
        end

endmodule

`default_nettype wire

/* vlog.f */
source/lstm_pkg.sv
source/grad_product.sv
source/dual_port_ram.sv
source/weight_updater.sv
source/lstm_weight_update.sv
verification/tb_lstm_weight_update.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
        -f vlog.f \
        --top-module tb_lstm_weight_update \
        -o sim_tb \
        || { echo "Build failed"; exit 1; }

./obj_dir/sim_tb | tee /dev/stderr | grep -q "^sim passed$" \
        && { echo "Simulation result: OK"; exit 0; } \
        || { echo "Simulation result: FAILED"; exit 1; }
